// File: Bender.yml
package:
  name: perf_optimizer

sources:
  - files:
      - hdl/perf_opt_pkg.sv
      - hdl/metric_window.sv
      - hdl/need_detector.sv
      - hdl/opt_sequencer.sv
      - hdl/knob_tuner.sv
      - hdl/perf_optimizer.sv
  - target: test
    files:
      - testbench/tb_checker.sv
      - testbench/tb_perf_optimizer.sv

// File: files.f
hdl/perf_opt_pkg.sv
hdl/metric_window.sv
hdl/need_detector.sv
hdl/opt_sequencer.sv
hdl/knob_tuner.sv
hdl/perf_optimizer.sv
testbench/tb_checker.sv
testbench/tb_perf_optimizer.sv

// File: hdl/knob_tuner.sv
`timescale 1ns/10ps
`default_nettype none

module knob_tuner
    import perf_opt_pkg::*;
(
    input  wire logic          clk_i,
    input  wire logic          rst_ni,
    input  wire opt_state_e    state_i,
    input  wire perf_metrics_t metrics_i,
    output opt_config_t        config_o
);

    opt_config_t cfg_q;

    // ==================================================
    // Knob registers
    // ==================================================

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cfg_q.cache_policy <= POLICY_LRU;
            cfg_q.bp_config    <= BP_CONSERVATIVE;
            cfg_q.pipe_mode    <= PIPE_NORMAL;
            cfg_q.power_mode   <= PWR_NORMAL;
        end else begin
            case (state_i)
                ST_CACHE_OPT: begin
                    // Low miss rates leave the policy as it is
                    if (metrics_i.cache_miss > CACHE_BAND_HI) begin
                        cfg_q.cache_policy <= POLICY_ADAPTIVE;
                    end else if (metrics_i.cache_miss > CACHE_BAND_MID) begin
                        cfg_q.cache_policy <= POLICY_LFU;
                    end else if (metrics_i.cache_miss > CACHE_BAND_LO) begin
                        cfg_q.cache_policy <= POLICY_LRU;
                    end
                end
                ST_BRANCH_OPT: begin
                    if (metrics_i.branch_miss > BRANCH_BAND_HI) begin
                        cfg_q.bp_config <= BP_AGGRESSIVE;
                    end else if (metrics_i.branch_miss > BRANCH_BAND_LO) begin
                        cfg_q.bp_config <= BP_MODERATE;
                    end else begin
                        cfg_q.bp_config <= BP_CONSERVATIVE;
                    end
                end
                ST_PIPE_OPT: begin
                    // Deeper pipe for heavier stalls
                    if (metrics_i.stalls > STALL_BAND_HI) begin
                        cfg_q.pipe_mode <= PIPE_DEEP;
                    end else if (metrics_i.stalls > STALL_BAND_LO) begin
                        cfg_q.pipe_mode <= PIPE_BALANCED;
                    end else begin
                        cfg_q.pipe_mode <= PIPE_NORMAL;
                    end
                end
                ST_POWER_OPT: begin
                    // Light load drops power, heavy load boosts it
                    if (metrics_i.load < LOAD_BAND_LO) begin
                        cfg_q.power_mode <= PWR_LOW;
                    end else if (metrics_i.load < LOAD_BAND_HI) begin
                        cfg_q.power_mode <= PWR_NORMAL;
                    end else begin
                        cfg_q.power_mode <= PWR_HIGH_PERF;
                    end
                end
                default: begin
                    // Monitor and analyze hold every knob
                end
            endcase
        end
    end

    assign config_o = cfg_q;

    // Only the defined policies are ever selected
    a_policy_range: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        cfg_q.cache_policy <= POLICY_ADAPTIVE
    );

endmodule

`default_nettype wire

// File: hdl/metric_window.sv
`timescale 1ns/10ps
`default_nettype none

module metric_window #(
    parameter int unsigned OPT_WINDOW = 8
) (
    input  wire logic        clk_i,
    input  wire logic        rst_ni,
    input  wire logic [31:0] ipc_i,
    output logic             window_start_o,
    output logic [31:0]      avg_ipc_o
);

    // Counter just wide enough for 0 .. OPT_WINDOW-1
    localparam int unsigned CNT_W = $clog2(OPT_WINDOW);

    logic [CNT_W-1:0]  cnt_q;
    logic              cnt_wrap;
    // Newest sample sits in entry 0
    logic [3:0][31:0]  ipc_hist_q;
    logic [33:0]       ipc_sum;

    // ==================================================
    // Window counter
    // ==================================================

    assign cnt_wrap = (cnt_q == CNT_W'(OPT_WINDOW - 1));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q <= '0;
        end else if (cnt_wrap) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Pulse for the first cycle of each window
    assign window_start_o = (cnt_q == '0);

    // ==================================================
    // IPC history and average
    // ==================================================

    // Sample taken on the last edge of the window, so the
    // average already holds it when the next window opens
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ipc_hist_q <= '0;
        end else if (cnt_wrap) begin
            ipc_hist_q <= {ipc_hist_q[2:0], ipc_i};
        end
    end

    // Two extra bits keep the four-way sum from overflowing
    always_comb begin
        ipc_sum = 34'(ipc_hist_q[0]) + 34'(ipc_hist_q[1])
                + 34'(ipc_hist_q[2]) + 34'(ipc_hist_q[3]);
        avg_ipc_o = 32'(ipc_sum >> 2);
    end

    // Counter never leaves its range
    a_cnt_range: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        32'(cnt_q) < OPT_WINDOW
    );

endmodule

`default_nettype wire

// File: hdl/need_detector.sv
`timescale 1ns/10ps
`default_nettype none

module need_detector
    import perf_opt_pkg::*;
(
    input  wire perf_metrics_t metrics_i,
    input  wire logic [31:0]   avg_ipc_i,
    output opt_need_t          needs_o,
    output logic [31:0]        gain_o
);

    // ==================================================
    // Need flags
    // ==================================================

    // Degraded looks at the windowed average, not the live IPC
    assign needs_o.degraded = (avg_ipc_i < IPC_TARGET);

    // Per-knob needs come straight from the live sample
    assign needs_o.cache    = (metrics_i.cache_miss > CACHE_MISS_THRESHOLD);
    assign needs_o.branch   = (metrics_i.branch_miss > BRANCH_MISS_THRESHOLD);
    assign needs_o.pipeline = (metrics_i.stalls > STALL_THRESHOLD);

    // Power tuning only when lightly loaded and the budget is tight
    assign needs_o.power    = (metrics_i.load < POWER_LOAD_LIMIT) &&
                              (metrics_i.budget < POWER_BUDGET_LIMIT);

    // ==================================================
    // Gain estimate
    // ==================================================

    always_comb begin
        logic [31:0] cache_gain;
        logic [31:0] branch_gain;
        logic [31:0] stall_gain;

        // Cache term
        if (metrics_i.cache_miss > CACHE_BAND_MID) begin
            cache_gain = CACHE_GAIN_HI;
        end else if (needs_o.cache) begin
            cache_gain = CACHE_GAIN_LO;
        end else begin
            cache_gain = '0;
        end

        // Branch term
        if (metrics_i.branch_miss > BRANCH_BAND_HI) begin
            branch_gain = BRANCH_GAIN_HI;
        end else if (needs_o.branch) begin
            branch_gain = BRANCH_GAIN_LO;
        end else begin
            branch_gain = '0;
        end

        // Stall term
        if (metrics_i.stalls > STALL_BAND_HI) begin
            stall_gain = STALL_GAIN_HI;
        end else if (needs_o.pipeline) begin
            stall_gain = STALL_GAIN_LO;
        end else begin
            stall_gain = '0;
        end

        // Largest possible sum is 37
        gain_o = cache_gain + branch_gain + stall_gain;
    end

endmodule

`default_nettype wire

// File: hdl/opt_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module opt_sequencer
    import perf_opt_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_ni,
    input  wire logic        window_start_i,
    input  wire opt_need_t   needs_i,
    input  wire power_mode_e power_mode_i,
    output opt_state_e       state_o,
    output logic             active_o,
    output logic             clock_gate_o
);

    opt_state_e state_q;
    opt_state_e state_d;

    // ==================================================
    // State register
    // ==================================================

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ST_MONITOR;
        end else begin
            state_q <= state_d;
        end
    end

    // ==================================================
    // Next state
    // ==================================================

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_MONITOR: begin
                // Episodes only open on a window boundary
                if (window_start_i && needs_i.degraded) begin
                    state_d = ST_ANALYZE;
                end
            end
            ST_ANALYZE: begin
                // Priority cache, branch, pipeline, power
                if (needs_i.cache) begin
                    state_d = ST_CACHE_OPT;
                end else if (needs_i.branch) begin
                    state_d = ST_BRANCH_OPT;
                end else if (needs_i.pipeline) begin
                    state_d = ST_PIPE_OPT;
                end else if (needs_i.power) begin
                    state_d = ST_POWER_OPT;
                end else begin
                    state_d = ST_MONITOR;
                end
            end
            // One apply cycle, then back to monitoring
            ST_CACHE_OPT,
            ST_BRANCH_OPT,
            ST_PIPE_OPT,
            ST_POWER_OPT: begin
                state_d = ST_MONITOR;
            end
            default: begin
                state_d = ST_MONITOR;
            end
        endcase
    end

    // ==================================================
    // Outputs
    // ==================================================

    assign state_o  = state_q;
    assign active_o = (state_q != ST_MONITOR);

    // Power mode here is still the one held before this episode
    // The tuner only updates it at the end of the apply cycle
    assign clock_gate_o = (state_q == ST_POWER_OPT) &&
                          (power_mode_i != PWR_HIGH_PERF);

    // Busy flag covers every non-idle state
    a_active_busy: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (state_q != ST_MONITOR) |-> active_o
    );

endmodule

`default_nettype wire

// File: hdl/perf_opt_pkg.sv
`default_nettype none

package perf_opt_pkg;

    // ==================================================
    // Thresholds and band limits
    // ==================================================

    // Average IPC below this starts a tuning episode
    localparam logic [31:0] IPC_TARGET = 32'd80;

    // Need thresholds, sized to the metric they are compared against
    localparam logic [15:0] CACHE_MISS_THRESHOLD  = 16'd10;
    localparam logic [15:0] BRANCH_MISS_THRESHOLD = 16'd5;
    localparam logic [7:0]  STALL_THRESHOLD       = 8'd10;
    localparam logic [7:0]  POWER_LOAD_LIMIT      = 8'd50;
    localparam logic [7:0]  POWER_BUDGET_LIMIT    = 8'd80;

    // Cache miss bands for the replacement policy
    localparam logic [15:0] CACHE_BAND_LO  = 16'd15;
    localparam logic [15:0] CACHE_BAND_MID = 16'd20;
    localparam logic [15:0] CACHE_BAND_HI  = 16'd25;

    // Branch miss bands for the predictor setting
    localparam logic [15:0] BRANCH_BAND_LO = 16'd10;
    localparam logic [15:0] BRANCH_BAND_HI = 16'd15;

    // Stall and load bands
    localparam logic [7:0] STALL_BAND_LO = 8'd20;
    localparam logic [7:0] STALL_BAND_HI = 8'd30;
    localparam logic [7:0] LOAD_BAND_LO  = 8'd30;
    localparam logic [7:0] LOAD_BAND_HI  = 8'd70;

    // Gain weights, high and low per term
    localparam logic [31:0] CACHE_GAIN_HI  = 32'd15;
    localparam logic [31:0] CACHE_GAIN_LO  = 32'd5;
    localparam logic [31:0] BRANCH_GAIN_HI = 32'd10;
    localparam logic [31:0] BRANCH_GAIN_LO = 32'd3;
    localparam logic [31:0] STALL_GAIN_HI  = 32'd12;
    localparam logic [31:0] STALL_GAIN_LO  = 32'd4;

    // ==================================================
    // Types
    // ==================================================

    // Input sample, 88 bits
    typedef struct packed {
        logic [31:0] ipc;
        logic [15:0] cache_miss;
        logic [15:0] branch_miss;
        logic [7:0]  stalls;
        logic [7:0]  load;
        logic [7:0]  budget;
    } perf_metrics_t;

    // Need flags from the detector
    typedef struct packed {
        logic degraded;
        logic cache;
        logic branch;
        logic pipeline;
        logic power;
    } opt_need_t;

    // Episode states
    typedef enum logic [2:0] {
        ST_MONITOR    = 3'd0,
        ST_ANALYZE    = 3'd1,
        ST_CACHE_OPT  = 3'd2,
        ST_BRANCH_OPT = 3'd3,
        ST_PIPE_OPT   = 3'd4,
        ST_POWER_OPT  = 3'd5
    } opt_state_e;

    typedef enum logic [2:0] {
        POLICY_LRU      = 3'd0,
        POLICY_LFU      = 3'd1,
        POLICY_RANDOM   = 3'd2,
        POLICY_FIFO     = 3'd3,
        POLICY_ADAPTIVE = 3'd4
    } cache_policy_e;

    // Predictor setting is one-hot
    typedef enum logic [3:0] {
        BP_CONSERVATIVE = 4'b0001,
        BP_MODERATE     = 4'b0100,
        BP_AGGRESSIVE   = 4'b1000
    } bp_config_e;

    typedef enum logic [1:0] {
        PIPE_NORMAL   = 2'd0,
        PIPE_BALANCED = 2'd1,
        PIPE_DEEP     = 2'd2
    } pipe_mode_e;

    typedef enum logic [3:0] {
        PWR_NORMAL    = 4'b0001,
        PWR_LOW       = 4'b0010,
        PWR_HIGH_PERF = 4'b1000
    } power_mode_e;

    // Output knobs, 13 bits
    typedef struct packed {
        cache_policy_e cache_policy;
        bp_config_e    bp_config;
        pipe_mode_e    pipe_mode;
        power_mode_e   power_mode;
    } opt_config_t;

endpackage

`default_nettype wire

// File: hdl/perf_optimizer.sv
`timescale 1ns/10ps
`default_nettype none

module perf_optimizer
    import perf_opt_pkg::*;
#(
    parameter int unsigned OPT_WINDOW = 8
) (
    input  wire logic          clk_i,
    input  wire logic          rst_ni,
    input  wire perf_metrics_t metrics_i,
    output opt_config_t        config_o,
    output logic               active_o,
    output logic               clock_gate_o,
    output logic [31:0]        gain_o
);

    // ==================================================
    // Internal nets
    // ==================================================

    logic        window_start;
    logic [31:0] avg_ipc;
    opt_need_t   needs;
    opt_state_e  state;

    // Windowed IPC average
    metric_window #(
        .OPT_WINDOW (OPT_WINDOW)
    ) u_metric_window (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .ipc_i          (metrics_i.ipc),
        .window_start_o (window_start),
        .avg_ipc_o      (avg_ipc)
    );

    // Needs and gain are purely combinational
    need_detector u_need_detector (
        .metrics_i (metrics_i),
        .avg_ipc_i (avg_ipc),
        .needs_o   (needs),
        .gain_o    (gain_o)
    );

    // Sequencer reads back the current power mode for clock gating
    opt_sequencer u_opt_sequencer (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .window_start_i (window_start),
        .needs_i        (needs),
        .power_mode_i   (config_o.power_mode),
        .state_o        (state),
        .active_o       (active_o),
        .clock_gate_o   (clock_gate_o)
    );

    knob_tuner u_knob_tuner (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .state_i   (state),
        .metrics_i (metrics_i),
        .config_o  (config_o)
    );

endmodule

`default_nettype wire

// File: testbench/tb_checker.sv
`timescale 1ns/10ps
`default_nettype none

module tb_checker
    import perf_opt_pkg::*;
#(
    parameter int unsigned OPT_WINDOW = 8
) (
    input  wire logic          clk_i,
    input  wire logic          rst_ni,
    input  wire perf_metrics_t metrics_i,
    input  wire opt_config_t   config_i,
    input  wire logic          active_i,
    input  wire logic          clock_gate_i,
    input  wire logic [31:0]   gain_i,
    input  wire logic [95:0]   row_name_i,
    input  wire logic          row_apply_i,
    input  wire logic          row_done_i,
    input  wire opt_config_t   exp_cfg_i,
    input  wire logic [31:0]   exp_gain_i,
    output logic [31:0]        pass_rows_o,
    output logic [31:0]        fail_rows_o,
    output logic [31:0]        mismatches_o
);

    localparam opt_config_t RESET_CFG = {POLICY_LRU, BP_CONSERVATIVE, PIPE_NORMAL, PWR_NORMAL};

    // Reference model state
    int unsigned cnt_m;
    logic [31:0] hist_m [4];
    opt_state_e  state_m;
    opt_config_t cfg_m;

    int row_errs   = 0;
    int pass_rows  = 0;
    int fail_rows  = 0;
    int mismatches = 0;

    assign pass_rows_o  = 32'(pass_rows);
    assign fail_rows_o  = 32'(fail_rows);
    assign mismatches_o = 32'(mismatches);

    // ==================================================
    // Rules of the optimizer
    // ==================================================

    // Episode order, cache first and power last
    function automatic opt_state_e next_state(
        input opt_state_e st, input logic win_start, input logic low_ipc, input perf_metrics_t m
    );
        opt_state_e nxt;
        nxt = ST_MONITOR;
        if (st == ST_MONITOR && win_start && low_ipc) nxt = ST_ANALYZE;
        else if (st == ST_ANALYZE) begin
            if (m.cache_miss > CACHE_MISS_THRESHOLD) nxt = ST_CACHE_OPT;
            else if (m.branch_miss > BRANCH_MISS_THRESHOLD) nxt = ST_BRANCH_OPT;
            else if (m.stalls > STALL_THRESHOLD) nxt = ST_PIPE_OPT;
            else if (m.load < POWER_LOAD_LIMIT && m.budget < POWER_BUDGET_LIMIT) nxt = ST_POWER_OPT;
        end
        return nxt;
    endfunction

    function automatic opt_config_t tuned_config(
        input opt_state_e st, input opt_config_t cur, input perf_metrics_t m
    );
        opt_config_t nxt;
        nxt = cur;
        case (st)
            ST_CACHE_OPT: begin
                // Below the low band the policy stays
                if (m.cache_miss > CACHE_BAND_HI) nxt.cache_policy = POLICY_ADAPTIVE;
                else if (m.cache_miss > CACHE_BAND_MID) nxt.cache_policy = POLICY_LFU;
                else if (m.cache_miss > CACHE_BAND_LO) nxt.cache_policy = POLICY_LRU;
            end
            ST_BRANCH_OPT: begin
                if (m.branch_miss > BRANCH_BAND_HI) nxt.bp_config = BP_AGGRESSIVE;
                else if (m.branch_miss > BRANCH_BAND_LO) nxt.bp_config = BP_MODERATE;
                else nxt.bp_config = BP_CONSERVATIVE;
            end
            ST_PIPE_OPT: begin
                if (m.stalls > STALL_BAND_HI) nxt.pipe_mode = PIPE_DEEP;
                else if (m.stalls > STALL_BAND_LO) nxt.pipe_mode = PIPE_BALANCED;
                else nxt.pipe_mode = PIPE_NORMAL;
            end
            ST_POWER_OPT: begin
                if (m.load < LOAD_BAND_LO) nxt.power_mode = PWR_LOW;
                else if (m.load < LOAD_BAND_HI) nxt.power_mode = PWR_NORMAL;
                else nxt.power_mode = PWR_HIGH_PERF;
            end
            default: begin
            end
        endcase
        return nxt;
    endfunction

    // Three terms, high weight above the upper band, low weight on need only
    function automatic logic [31:0] gain_of(input perf_metrics_t m);
        logic [31:0] g;
        g = 0;
        if (m.cache_miss > CACHE_BAND_MID) g += CACHE_GAIN_HI;
        else if (m.cache_miss > CACHE_MISS_THRESHOLD) g += CACHE_GAIN_LO;
        if (m.branch_miss > BRANCH_BAND_HI) g += BRANCH_GAIN_HI;
        else if (m.branch_miss > BRANCH_MISS_THRESHOLD) g += BRANCH_GAIN_LO;
        if (m.stalls > STALL_BAND_HI) g += STALL_GAIN_HI;
        else if (m.stalls > STALL_THRESHOLD) g += STALL_GAIN_LO;
        return g;
    endfunction

    // ==================================================
    // Model update on the rising edge
    // ==================================================

    always @(posedge clk_i or negedge rst_ni) begin
        longint unsigned sum;
        if (!rst_ni) begin
            cnt_m   <= 0;
            state_m <= ST_MONITOR;
            cfg_m   <= RESET_CFG;
            for (int k = 0; k < 4; k++) begin
                hist_m[k] <= '0;
            end
        end else begin
            sum = longint'(hist_m[0]) + longint'(hist_m[1]) + longint'(hist_m[2])
                + longint'(hist_m[3]);
            // Window start is counter 0
            state_m <= next_state(state_m, cnt_m == 0, (sum / 4) < IPC_TARGET, metrics_i);
            cfg_m   <= tuned_config(state_m, cfg_m, metrics_i);
            if (cnt_m == OPT_WINDOW - 1) begin
                cnt_m     <= 0;
                hist_m[3] <= hist_m[2];
                hist_m[2] <= hist_m[1];
                hist_m[1] <= hist_m[0];
                hist_m[0] <= metrics_i.ipc;
            end else begin
                cnt_m <= cnt_m + 1;
            end
        end
    end

    // ==================================================
    // Comparisons on the falling edge
    // ==================================================

    task automatic check_value(input string what, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (act_v !== exp_v) begin
            $display("ERR %0s: %0s expected 0x%0h actual 0x%0h", row_name_i, what, exp_v, act_v);
            row_errs++;
            mismatches++;
        end
    endtask

    always @(negedge clk_i) begin
        logic exp_gate;
        // Gating follows the power mode held before the episode
        exp_gate = (state_m == ST_POWER_OPT) && (cfg_m.power_mode != PWR_HIGH_PERF);
        check_value("active_o", 32'(state_m != ST_MONITOR), 32'(active_i));
        check_value("clock_gate_o", 32'(exp_gate), 32'(clock_gate_i));
        check_value("config_o", 32'(cfg_m), 32'(config_i));
        if (row_apply_i) begin
            check_value("gain_o", gain_of(metrics_i), gain_i);
            check_value("gain_o against table", exp_gain_i, gain_i);
        end
        if (row_done_i) begin
            check_value("config_o against table", 32'(exp_cfg_i), 32'(config_i));
            if (row_errs == 0) begin
                pass_rows++;
                $display("ok   %0s", row_name_i);
            end else begin
                fail_rows++;
                $display("fail %0s with %0d mismatches", row_name_i, row_errs);
            end
            row_errs = 0;
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_perf_optimizer.sv
`timescale 1ns/10ps
`default_nettype none

module tb_perf_optimizer
    import perf_opt_pkg::*;
();

    localparam int unsigned OPT_WINDOW = 8;
    localparam int          NUM_ROWS   = 15;

    // One stimulus row with the knobs expected once it has run
    typedef struct packed {
        logic [95:0]   name;
        perf_metrics_t metrics;
        logic [7:0]    windows;
        opt_config_t   exp_cfg;
        logic [31:0]   exp_gain;
    } row_t;

    row_t          rows [NUM_ROWS];

    logic          clk;
    logic          rst_n;
    perf_metrics_t metrics;
    opt_config_t   dut_config;
    logic          dut_active;
    logic          dut_gate;
    logic [31:0]   dut_gain;

    // Row markers for the checker
    logic [95:0]   row_name;
    logic          row_apply;
    logic          row_done;
    opt_config_t   exp_cfg;
    logic [31:0]   exp_gain;
    logic [31:0]   pass_rows;
    logic [31:0]   fail_rows;
    logic [31:0]   mismatches;

    int unsigned   cycle_cnt   = 0;
    int unsigned   cycle_limit = 0;

    // ==================================================
    // Clock, DUT and checker
    // ==================================================

    always #50 clk = ~clk;

    perf_optimizer #(
        .OPT_WINDOW (OPT_WINDOW)
    ) u_dut (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .metrics_i    (metrics),
        .config_o     (dut_config),
        .active_o     (dut_active),
        .clock_gate_o (dut_gate),
        .gain_o       (dut_gain)
    );

    tb_checker #(
        .OPT_WINDOW (OPT_WINDOW)
    ) u_checker (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .metrics_i    (metrics),
        .config_i     (dut_config),
        .active_i     (dut_active),
        .clock_gate_i (dut_gate),
        .gain_i       (dut_gain),
        .row_name_i   (row_name),
        .row_apply_i  (row_apply),
        .row_done_i   (row_done),
        .exp_cfg_i    (exp_cfg),
        .exp_gain_i   (exp_gain),
        .pass_rows_o  (pass_rows),
        .fail_rows_o  (fail_rows),
        .mismatches_o (mismatches)
    );

    // Run limit comes from the table length
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, the row sequence never finished", cycle_cnt);
            $display(">>> FAIL");
            $finish;
        end
    end

    // ==================================================
    // Stimulus table
    // ==================================================

    function automatic row_t make_row(
        input logic [95:0] name,
        input int          ipc,
        input int          cache,
        input int          branch,
        input int          stalls,
        input int          load,
        input int          budget,
        input int          windows,
        input cache_policy_e pol,
        input bp_config_e  bp,
        input pipe_mode_e  pm,
        input power_mode_e pw,
        input int          gain
    );
        row_t r;
        r.name                = name;
        r.metrics.ipc         = 32'(ipc);
        r.metrics.cache_miss  = 16'(cache);
        r.metrics.branch_miss = 16'(branch);
        r.metrics.stalls      = 8'(stalls);
        r.metrics.load        = 8'(load);
        r.metrics.budget      = 8'(budget);
        r.windows             = 8'(windows);
        r.exp_cfg.cache_policy = pol;
        r.exp_cfg.bp_config    = bp;
        r.exp_cfg.pipe_mode    = pm;
        r.exp_cfg.power_mode   = pw;
        r.exp_gain            = 32'(gain);
        return r;
    endfunction

    task automatic build_table();
        // Name, ipc, cache, branch, stalls, load, budget, windows, then expected knobs and gain
        rows[0]  = make_row("reset", 200, 0, 0, 0, 60, 90, 2,
                            POLICY_LRU, BP_CONSERVATIVE, PIPE_NORMAL, PWR_NORMAL, 0);
        // Cache need raised but the average is above target
        rows[1]  = make_row("high_ipc", 200, 27, 0, 0, 60, 90, 3,
                            POLICY_LRU, BP_CONSERVATIVE, PIPE_NORMAL, PWR_NORMAL, 15);
        // Average falls back towards the target
        rows[2]  = make_row("drain", 0, 0, 0, 0, 60, 90, 3,
                            POLICY_LRU, BP_CONSERVATIVE, PIPE_NORMAL, PWR_NORMAL, 0);
        rows[3]  = make_row("cache_27", 0, 27, 0, 0, 60, 90, 1,
                            POLICY_ADAPTIVE, BP_CONSERVATIVE, PIPE_NORMAL, PWR_NORMAL, 15);
        rows[4]  = make_row("cache_22", 0, 22, 0, 0, 60, 90, 1,
                            POLICY_LFU, BP_CONSERVATIVE, PIPE_NORMAL, PWR_NORMAL, 15);
        rows[5]  = make_row("cache_17", 0, 17, 0, 0, 60, 90, 1,
                            POLICY_LRU, BP_CONSERVATIVE, PIPE_NORMAL, PWR_NORMAL, 5);
        rows[6]  = make_row("branch_18", 0, 8, 18, 0, 60, 90, 1,
                            POLICY_LRU, BP_AGGRESSIVE, PIPE_NORMAL, PWR_NORMAL, 10);
        rows[7]  = make_row("branch_12", 0, 8, 12, 0, 60, 90, 1,
                            POLICY_LRU, BP_MODERATE, PIPE_NORMAL, PWR_NORMAL, 3);
        rows[8]  = make_row("branch_8", 0, 8, 8, 0, 60, 90, 1,
                            POLICY_LRU, BP_CONSERVATIVE, PIPE_NORMAL, PWR_NORMAL, 3);
        rows[9]  = make_row("pipe_35", 0, 8, 3, 35, 60, 90, 1,
                            POLICY_LRU, BP_CONSERVATIVE, PIPE_DEEP, PWR_NORMAL, 12);
        rows[10] = make_row("pipe_25", 0, 8, 3, 25, 60, 90, 1,
                            POLICY_LRU, BP_CONSERVATIVE, PIPE_BALANCED, PWR_NORMAL, 4);
        rows[11] = make_row("pipe_15", 0, 8, 3, 15, 60, 90, 1,
                            POLICY_LRU, BP_CONSERVATIVE, PIPE_NORMAL, PWR_NORMAL, 4);
        rows[12] = make_row("power_20", 0, 8, 3, 5, 20, 40, 1,
                            POLICY_LRU, BP_CONSERVATIVE, PIPE_NORMAL, PWR_LOW, 0);
        rows[13] = make_row("power_45", 0, 8, 3, 5, 45, 40, 1,
                            POLICY_LRU, BP_CONSERVATIVE, PIPE_NORMAL, PWR_NORMAL, 0);
        // Only the analyze pulse, knobs untouched
        rows[14] = make_row("no_needs", 0, 8, 3, 5, 60, 90, 1,
                            POLICY_LRU, BP_CONSERVATIVE, PIPE_NORMAL, PWR_NORMAL, 0);
    endtask

    // Hold a row for its windows, flag first and last cycle
    task automatic run_row(input row_t r);
        metrics   = r.metrics;
        row_name  = r.name;
        exp_cfg   = r.exp_cfg;
        exp_gain  = r.exp_gain;
        row_apply = 1'b1;
        @(posedge clk);
        #1;
        row_apply = 1'b0;
        repeat (int'(r.windows) * OPT_WINDOW - 2) @(posedge clk);
        #1;
        row_done = 1'b1;
        @(posedge clk);
        #1;
        row_done = 1'b0;
    endtask

    // ==================================================
    // Main sequence
    // ==================================================

    initial begin
        int unsigned total_windows;
        build_table();
        total_windows = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            total_windows += int'(rows[i].windows);
        end
        cycle_limit = (total_windows + 4) * OPT_WINDOW + 20;

        clk       = 1'b0;
        rst_n     = 1'b0;
        metrics   = rows[0].metrics;
        row_name  = rows[0].name;
        exp_cfg   = rows[0].exp_cfg;
        exp_gain  = rows[0].exp_gain;
        row_apply = 1'b0;
        row_done  = 1'b0;

        // Release lands on the first window start
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(rows[i]);
        end

        $display("Rows passed %0d, rows failed %0d, mismatches %0d",
                 pass_rows, fail_rows, mismatches);
        if (fail_rows == 0 && mismatches == 0 && pass_rows == NUM_ROWS) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
